//--- common/xbus_pkg.sv
// Xbus shared definitions
package xbus_pkg;

   // Bus widths.
   localparam int addr_width = 22;
   localparam int data_width = 32;

   // Unibus adapter register page, 64 words.
   localparam logic [addr_width-1:0] unibus_base = 22'o17773000;
   localparam int unibus_page_bits = 6;

   // Quiet ranges that read zero and ignore writes.
   localparam logic [addr_width-1:0] other_page_a = 22'o17777700;
   localparam int other_a_bits = 6;            // 64 words.
   localparam logic [addr_width-1:0] other_page_b = 22'o17740000;
   localparam int other_b_bits = 12;           // 4096 words.

   // A timed-out address above these floors sets an nxm bit.
   localparam logic [addr_width-1:0] unibus_nxm_floor = 22'o17400000;
   localparam logic [addr_width-1:0] xbus_nxm_floor = 22'o17000000;

   // Adapter registers by page offset.
   typedef enum logic [unibus_page_bits-1:0] {
      reg_none   = 6'o00,
      reg_prom   = 6'o05,
      reg_ints   = 6'o20,
      reg_status = 6'o22
   } unibus_reg_t;

   // Bus controller states.
   typedef enum logic [1:0] {
      st_idle,
      st_bus,
      st_resp
   } ctl_state_t;

   // Interrupt register layout.
   localparam int ints_unibus_int_bit = 15;
   localparam int ints_xbus_int_bit = 14;
   localparam int ints_enable_bit = 10;
   localparam int ints_vector_lsb = 2;
   localparam int vector_width = 8;

   // Status register layout.
   localparam int status_unibus_nxm_bit = 3;
   localparam int status_xbus_nxm_bit = 0;

endpackage

//--- logic/xbus_ctl.sv
// Xbus bus controller
`timescale 1ns/1ps

module xbus_ctl #(
   parameter int timeout_cycles = 8
) (
   input  logic                              clk,
   input  logic                              reset,
   input  logic                              cmd_valid,
   input  logic                              cmd_write,
   input  logic [xbus_pkg::addr_width-1:0]   cmd_addr,
   input  logic [xbus_pkg::data_width-1:0]   cmd_data,
   output logic                              cmd_ready,
   output logic                              resp_valid,
   output logic [xbus_pkg::data_width-1:0]   resp_data,
   output logic                              resp_nxm,
   input  logic                              resp_ready,
   output logic                              req,
   output logic                              write,
   output logic [xbus_pkg::addr_width-1:0]   addr,
   output logic [xbus_pkg::data_width-1:0]   datain,
   output logic                              timeout,
   input  logic                              dec_unibus,
   input  logic                              dec_ram,
   input  logic                              ack_unibus,
   input  logic                              ack_ram,
   input  logic [xbus_pkg::data_width-1:0]   rdata_unibus,
   input  logic [xbus_pkg::data_width-1:0]   rdata_ram
);

   localparam int cnt_bits = $clog2(timeout_cycles + 1);

   xbus_pkg::ctl_state_t state;
   logic started;
   logic [cnt_bits-1:0] idle_cnt;
   logic bus_decode;
   logic bus_ack;
   logic [xbus_pkg::data_width-1:0] bus_rdata;
   logic cmd_fire;
   logic timeout_hit;

   // Only one board decodes any address.
   assign bus_decode = dec_unibus | dec_ram;
   assign bus_ack = ack_unibus | ack_ram;
   assign bus_rdata = rdata_unibus | rdata_ram;

   assign cmd_ready = started && (state == xbus_pkg::st_idle);
   assign cmd_fire = cmd_valid && cmd_ready;

   // Last undecoded cycle before the limit.
   assign timeout_hit = (state == xbus_pkg::st_bus) && !bus_decode &&
                        (idle_cnt == cnt_bits'(timeout_cycles - 1));

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state <= xbus_pkg::st_idle;
         started <= 1'b0;
         req <= 1'b0;
         timeout <= 1'b0;
         resp_valid <= 1'b0;
         idle_cnt <= '0;
      end
      else
      begin
         started <= 1'b1;
         timeout <= timeout_hit;
         case (state)
            xbus_pkg::st_idle:
               if (cmd_fire)
               begin
                  state <= xbus_pkg::st_bus;
                  req <= 1'b1;
                  idle_cnt <= '0;
               end
            xbus_pkg::st_bus:
               if (bus_ack || timeout)
               begin
                  state <= xbus_pkg::st_resp;
                  req <= 1'b0;
                  resp_valid <= 1'b1;
               end
               else if (!bus_decode)
                  idle_cnt <= idle_cnt + 1'b1;    // Counts cycles nobody claims.
            xbus_pkg::st_resp:
               if (resp_ready)
               begin
                  state <= xbus_pkg::st_idle;  // Stale ack drains here.
                  resp_valid <= 1'b0;
               end
            default:
               state <= xbus_pkg::st_idle;
         endcase
      end
   end

   // Command and response payload.
   always_ff @(posedge clk)
   begin
      if (cmd_fire)
      begin
         write <= cmd_write;
         addr <= cmd_addr;
         datain <= cmd_data;
      end
      if (state == xbus_pkg::st_bus)
      begin
         if (bus_ack)
         begin
            resp_data <= bus_rdata;
            resp_nxm <= 1'b0;
         end
         else if (timeout)
         begin
            resp_data <= '0;
            resp_nxm <= 1'b1;
         end
      end
   end

endmodule

//--- unibus/xbus_unibus.sv
// Unibus adapter board
`timescale 1ns/1ps

module xbus_unibus (
   input  logic                              clk,
   input  logic                              reset,
   input  logic [xbus_pkg::addr_width-1:0]   addr,
   input  logic [xbus_pkg::data_width-1:0]   datain,
   input  logic                              req,
   input  logic                              write,
   input  logic                              timeout,
   output logic [xbus_pkg::data_width-1:0]   dataout,
   output logic                              ack,
   output logic                              decode,
   output logic                              promdisable
);

   localparam int aw = xbus_pkg::addr_width;
   localparam int pb = xbus_pkg::unibus_page_bits;

   logic in_unibus;
   logic in_other;
   logic decode_unibus;
   logic decode_other;
   logic [1:0] ack_delayed;
   xbus_pkg::unibus_reg_t reg_sel;
   logic prom_key;
   logic ints_write;
   logic status_write;
   logic [xbus_pkg::data_width-1:0] bus_ints;
   logic [xbus_pkg::data_width-1:0] bus_status;
   logic [xbus_pkg::data_width-1:0] read_value;

   logic unibus_nxm;
   logic xbus_nxm;
   logic unibus_int_en;

   assign in_unibus = (addr[aw-1:pb] == xbus_pkg::unibus_base[aw-1:pb]);
   assign in_other =
      (addr[aw-1:xbus_pkg::other_a_bits] ==
       xbus_pkg::other_page_a[aw-1:xbus_pkg::other_a_bits]) ||
      (addr[aw-1:xbus_pkg::other_b_bits] ==
       xbus_pkg::other_page_b[aw-1:xbus_pkg::other_b_bits]);

   assign decode_unibus = req && in_unibus;
   assign decode_other = req && in_other;
   assign decode = decode_unibus || decode_other;
   assign ack = ack_delayed[1];

   always_comb
   begin
      case (addr[pb-1:0])
         xbus_pkg::reg_prom:   reg_sel = xbus_pkg::reg_prom;
         xbus_pkg::reg_ints:   reg_sel = xbus_pkg::reg_ints;
         xbus_pkg::reg_status: reg_sel = xbus_pkg::reg_status;
         default:              reg_sel = xbus_pkg::reg_none;
      endcase
   end

   assign prom_key = datain[5] && datain[2] && !datain[0];
   assign ints_write = decode_unibus && write && (reg_sel == xbus_pkg::reg_ints);
   assign status_write = decode_unibus && write && (reg_sel == xbus_pkg::reg_status);

   // Interrupt and vector fields read zero.
   always_comb
   begin
      bus_ints = '0;
      bus_ints[xbus_pkg::ints_enable_bit] = unibus_int_en;
   end

   always_comb
   begin
      bus_status = '0;
      bus_status[xbus_pkg::status_unibus_nxm_bit] = unibus_nxm;
      bus_status[xbus_pkg::status_xbus_nxm_bit] = xbus_nxm;
   end

   // Other ranges fall through to zero.
   always_comb
   begin
      read_value = '0;
      if (decode_unibus && !write)
      begin
         case (reg_sel)
            xbus_pkg::reg_ints:   read_value = bus_ints;
            xbus_pkg::reg_status: read_value = bus_status;
            default:              read_value = '0;
         endcase
      end
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         ack_delayed <= 2'b00;
         promdisable <= 1'b0;
      end
      else
      begin
         ack_delayed <= {ack_delayed[0], decode};
         promdisable <= decode_unibus && write && (reg_sel == xbus_pkg::reg_prom) &&
                        prom_key;
      end
   end

   always_ff @(posedge clk)
   begin
      dataout <= read_value;
   end

   always_ff @(posedge clk)
   begin
      if (reset)
         unibus_int_en <= 1'b0;
      else if (ints_write)
         unibus_int_en <= datain[xbus_pkg::ints_enable_bit];
   end

   // Timeout wins over a status clear.
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         unibus_nxm <= 1'b0;
         xbus_nxm <= 1'b0;
      end
      else if (timeout)
      begin
         if (addr > xbus_pkg::unibus_nxm_floor)
            unibus_nxm <= 1'b1;
         else if (addr > xbus_pkg::xbus_nxm_floor)
            xbus_nxm <= 1'b1;
      end
      else if (status_write)
      begin
         unibus_nxm <= 1'b0;
         xbus_nxm <= 1'b0;
      end
   end

endmodule

//--- logic/xbus_ram.sv
// Xbus main memory board
`timescale 1ns/1ps

module xbus_ram #(
   parameter int ram_addr_bits = 10
) (
   input  logic                              clk,
   input  logic                              reset,
   input  logic [xbus_pkg::addr_width-1:0]   addr,
   input  logic [xbus_pkg::data_width-1:0]   datain,
   input  logic                              req,
   input  logic                              write,
   output logic [xbus_pkg::data_width-1:0]   dataout,
   output logic                              ack,
   output logic                              decode
);

   localparam int depth = 2 ** ram_addr_bits;

   logic [xbus_pkg::data_width-1:0] mem [depth];
   logic [ram_addr_bits-1:0] word_addr;
   logic in_ram;
   logic [1:0] ack_delayed;

   // Low addresses belong to memory.
   assign in_ram = (addr[xbus_pkg::addr_width-1:ram_addr_bits] == '0);
   assign decode = req && in_ram;
   assign word_addr = addr[ram_addr_bits-1:0];
   assign ack = ack_delayed[1];

   always_ff @(posedge clk)
   begin
      if (reset)
         ack_delayed <= 2'b00;
      else
         ack_delayed <= {ack_delayed[0], decode};
   end

   always_ff @(posedge clk)
   begin
      if (decode && write)
         mem[word_addr] <= datain;
   end

   // Zero when not reading.
   always_ff @(posedge clk)
   begin
      if (decode && !write)
         dataout <= mem[word_addr];
      else
         dataout <= '0;
   end

endmodule

//--- logic/xbus_top.sv
// Xbus system top level
`timescale 1ns/1ps

module xbus_top #(
   parameter int ram_addr_bits = 10,
   parameter int timeout_cycles = 8
) (
   input  logic                              clk,
   input  logic                              reset,
   input  logic                              cmd_valid,
   input  logic                              cmd_write,
   input  logic [xbus_pkg::addr_width-1:0]   cmd_addr,
   input  logic [xbus_pkg::data_width-1:0]   cmd_data,
   output logic                              cmd_ready,
   output logic                              resp_valid,
   output logic [xbus_pkg::data_width-1:0]   resp_data,
   output logic                              resp_nxm,
   input  logic                              resp_ready,
   output logic                              promdisable
);

   logic req;
   logic write;
   logic [xbus_pkg::addr_width-1:0] addr;
   logic [xbus_pkg::data_width-1:0] datain;
   logic timeout;
   logic dec_unibus;
   logic dec_ram;
   logic ack_unibus;
   logic ack_ram;
   logic [xbus_pkg::data_width-1:0] rdata_unibus;
   logic [xbus_pkg::data_width-1:0] rdata_ram;

   xbus_ctl #(
      .timeout_cycles(timeout_cycles)
   ) xbus_ctl_inst (
      .clk(clk),
      .reset(reset),
      .cmd_valid(cmd_valid),
      .cmd_write(cmd_write),
      .cmd_addr(cmd_addr),
      .cmd_data(cmd_data),
      .cmd_ready(cmd_ready),
      .resp_valid(resp_valid),
      .resp_data(resp_data),
      .resp_nxm(resp_nxm),
      .resp_ready(resp_ready),
      .req(req),
      .write(write),
      .addr(addr),
      .datain(datain),
      .timeout(timeout),
      .dec_unibus(dec_unibus),
      .dec_ram(dec_ram),
      .ack_unibus(ack_unibus),
      .ack_ram(ack_ram),
      .rdata_unibus(rdata_unibus),
      .rdata_ram(rdata_ram)
   );

   xbus_unibus xbus_unibus_inst (
      .clk(clk),
      .reset(reset),
      .addr(addr),
      .datain(datain),
      .req(req),
      .write(write),
      .timeout(timeout),
      .dataout(rdata_unibus),
      .ack(ack_unibus),
      .decode(dec_unibus),
      .promdisable(promdisable)
   );

   xbus_ram #(
      .ram_addr_bits(ram_addr_bits)
   ) xbus_ram_inst (
      .clk(clk),
      .reset(reset),
      .addr(addr),
      .datain(datain),
      .req(req),
      .write(write),
      .dataout(rdata_ram),
      .ack(ack_ram),
      .decode(dec_ram)
   );

endmodule

//--- test/xbus_clk_gen.sv
// Testbench clock and reset
`timescale 1ns/1ps

module xbus_clk_gen #(
   parameter int period_ns = 100,
   parameter int reset_cycles = 4
) (
   output logic clk,
   output logic reset
);

   initial
   begin
      clk = 1'b0;
      forever #(period_ns / 2) clk = ~clk;
   end

   initial
   begin
      reset <= 1'b1;
      repeat (reset_cycles) @(posedge clk);
      reset <= 1'b0;                   // Released on an edge.
   end

endmodule

//--- test/xbus_checker.sv
// Xbus response checker
`timescale 1ns/1ps

module xbus_checker #(
   parameter int timeout_cycles = 8
) (
   input  logic                              clk,
   input  logic                              reset,
   input  logic                              cmd_valid,
   input  logic                              cmd_ready,
   input  logic                              resp_valid,
   input  logic                              resp_ready,
   input  logic [xbus_pkg::data_width-1:0]   resp_data,
   input  logic                              resp_nxm,
   input  logic                              promdisable,
   input  logic [xbus_pkg::data_width-1:0]   exp_data,
   input  logic                              exp_nxm,
   input  logic                              exp_prom,
   input  logic                              report,
   output int                                error_count,
   output int                                response_count
);

   logic pending;
   logic seen_valid;
   logic prom_seen;
   logic held;
   logic reported;
   int cycles;
   logic [xbus_pkg::data_width-1:0] want_data;
   logic want_nxm;
   logic want_prom;
   logic [xbus_pkg::data_width-1:0] held_data;
   logic held_nxm;

   // Edges from acceptance until resp_valid is seen.
   function automatic int expected_latency(input logic nxm);
      if (nxm)
         return timeout_cycles + 2;    // Req, timeout pulse, then response.
      return 4;
   endfunction

   task automatic flag_error(input string msg);
      error_count = error_count + 1;
      $display("ERR t=%0t %s", $time, msg);
   endtask

   always @(posedge clk)
   begin
      if (reset)
      begin
         pending = 1'b0;
         held = 1'b0;
         reported = 1'b0;
      end
      else
      begin
         if (held && !resp_valid)
            flag_error("resp_valid dropped while resp_ready was low");
         else if (held && (resp_data !== held_data || resp_nxm !== held_nxm))
            flag_error($sformatf("stalled response changed to %h nxm %b", resp_data, resp_nxm));
         if (resp_valid && cmd_ready)
            flag_error("cmd_ready high while a response is pending");
         if (pending)
         begin
            cycles = cycles + 1;
            if (promdisable)
               prom_seen = 1'b1;
            if (resp_valid && !seen_valid)
            begin
               seen_valid = 1'b1;
               if (cycles != expected_latency(want_nxm))
                  flag_error($sformatf("latency %0d, expected %0d",
                                       cycles, expected_latency(want_nxm)));
            end
            if (resp_valid && resp_ready)
            begin
               response_count = response_count + 1;
               pending = 1'b0;
               if (resp_data !== want_data)
                  flag_error($sformatf("data %h, expected %h", resp_data, want_data));
               if (resp_nxm !== want_nxm)
                  flag_error($sformatf("nxm %b, expected %b", resp_nxm, want_nxm));
               if (prom_seen !== want_prom)
                  flag_error($sformatf("promdisable %b, expected %b", prom_seen, want_prom));
            end
         end
         else
         begin
            if (promdisable)
               flag_error("promdisable high with no command in flight");
            if (resp_valid)
               flag_error("resp_valid high with no command in flight");
         end
         if (cmd_valid && cmd_ready)
         begin
            pending = 1'b1;
            seen_valid = 1'b0;
            prom_seen = 1'b0;
            cycles = 0;
            want_data = exp_data;
            want_nxm = exp_nxm;
            want_prom = exp_prom;
         end
         held = resp_valid && !resp_ready;
         held_data = resp_data;
         held_nxm = resp_nxm;
         if (report && !reported)
         begin
            reported = 1'b1;
            $display("Checker: %0d responses, %0d errors", response_count, error_count);
         end
      end
   end

endmodule

//--- test/xbus_tb.sv
// Xbus testbench top
`timescale 1ns/1ps

module xbus_tb;

   localparam int ram_addr_bits = 10;
   localparam int timeout_cycles = 8;
   localparam int max_entries = 32;
   localparam int aw = xbus_pkg::addr_width;
   localparam int dw = xbus_pkg::data_width;

   logic clk;
   logic reset;
   logic cmd_valid;
   logic cmd_write;
   logic [aw-1:0] cmd_addr;
   logic [dw-1:0] cmd_data;
   logic cmd_ready;
   logic resp_valid;
   logic [dw-1:0] resp_data;
   logic resp_nxm;
   logic resp_ready;
   logic promdisable;
   logic [dw-1:0] exp_data;
   logic exp_nxm;
   logic exp_prom;
   logic report;
   int error_count;
   int response_count;

   // Stimulus table.
   logic tbl_write [max_entries];
   logic [aw-1:0] tbl_addr [max_entries];
   logic [dw-1:0] tbl_data [max_entries];
   logic [dw-1:0] tbl_exp_data [max_entries];
   logic tbl_exp_nxm [max_entries];
   logic tbl_exp_prom [max_entries];
   int n_entries;
   int cycle_count;
   int cycle_limit;
   int idx;
   int stall;
   logic [31:0] rand_word;
   logic [aw-1:0] ram_addr [4];
   logic [dw-1:0] ram_data [4];

   xbus_clk_gen #(.period_ns(100), .reset_cycles(4)) xbus_clk_gen_inst (
      .clk(clk),
      .reset(reset)
   );

   xbus_top #(
      .ram_addr_bits(ram_addr_bits),
      .timeout_cycles(timeout_cycles)
   ) xbus_top_inst (
      .clk(clk),
      .reset(reset),
      .cmd_valid(cmd_valid),
      .cmd_write(cmd_write),
      .cmd_addr(cmd_addr),
      .cmd_data(cmd_data),
      .cmd_ready(cmd_ready),
      .resp_valid(resp_valid),
      .resp_data(resp_data),
      .resp_nxm(resp_nxm),
      .resp_ready(resp_ready),
      .promdisable(promdisable)
   );

   xbus_checker #(.timeout_cycles(timeout_cycles)) xbus_checker_inst (
      .clk(clk),
      .reset(reset),
      .cmd_valid(cmd_valid),
      .cmd_ready(cmd_ready),
      .resp_valid(resp_valid),
      .resp_ready(resp_ready),
      .resp_data(resp_data),
      .resp_nxm(resp_nxm),
      .promdisable(promdisable),
      .exp_data(exp_data),
      .exp_nxm(exp_nxm),
      .exp_prom(exp_prom),
      .report(report),
      .error_count(error_count),
      .response_count(response_count)
   );

   function automatic logic [aw-1:0] reg_address(input xbus_pkg::unibus_reg_t r);
      return {xbus_pkg::unibus_base[aw-1:xbus_pkg::unibus_page_bits], r};
   endfunction

   task automatic add_entry(input logic w, input logic [aw-1:0] a, input logic [dw-1:0] d,
                            input logic [dw-1:0] ed, input logic en, input logic ep);
      tbl_write[n_entries] = w;
      tbl_addr[n_entries] = a;
      tbl_data[n_entries] = d;
      tbl_exp_data[n_entries] = ed;
      tbl_exp_nxm[n_entries] = en;
      tbl_exp_prom[n_entries] = ep;
      n_entries = n_entries + 1;
   endtask

   task automatic build_table();
      for (int i = 0; i < 4; i++)
      begin
         rand_word = $urandom;
         ram_addr[i] = {12'd0, 2'(i), rand_word[7:0]};    // Distinct words.
         ram_data[i] = $urandom;
         add_entry(1'b1, ram_addr[i], ram_data[i], '0, 1'b0, 1'b0);
      end
      for (int i = 0; i < 4; i++)
         add_entry(1'b0, ram_addr[i], '0, ram_data[i], 1'b0, 1'b0);
      add_entry(1'b1, reg_address(xbus_pkg::reg_ints), 32'h0000_ffff, '0, 1'b0, 1'b0);
      add_entry(1'b0, reg_address(xbus_pkg::reg_ints), '0, 32'h0000_0400, 1'b0, 1'b0);
      add_entry(1'b1, reg_address(xbus_pkg::reg_ints), 32'h0000_fbff, '0, 1'b0, 1'b0);
      add_entry(1'b0, reg_address(xbus_pkg::reg_ints), '0, '0, 1'b0, 1'b0);
      add_entry(1'b1, reg_address(xbus_pkg::reg_prom), 32'h0000_0024, '0, 1'b0, 1'b1);
      add_entry(1'b1, reg_address(xbus_pkg::reg_prom), 32'h0000_0025, '0, 1'b0, 1'b0);
      add_entry(1'b0, xbus_pkg::other_page_a + 22'o12, '0, '0, 1'b0, 1'b0);
      add_entry(1'b0, xbus_pkg::other_page_b + 22'o1234, '0, '0, 1'b0, 1'b0);
      add_entry(1'b0, 22'o17500000, '0, '0, 1'b1, 1'b0);       // Unibus nxm.
      add_entry(1'b0, reg_address(xbus_pkg::reg_status), '0, 32'h0000_0008, 1'b0, 1'b0);
      add_entry(1'b1, reg_address(xbus_pkg::reg_status), '0, '0, 1'b0, 1'b0);
      add_entry(1'b0, 22'o17100000, '0, '0, 1'b1, 1'b0);       // Xbus nxm.
      add_entry(1'b0, reg_address(xbus_pkg::reg_status), '0, 32'h0000_0001, 1'b0, 1'b0);
      add_entry(1'b1, reg_address(xbus_pkg::reg_status), '0, '0, 1'b0, 1'b0);
      add_entry(1'b0, reg_address(xbus_pkg::reg_status), '0, '0, 1'b0, 1'b0);
   endtask

   always @(posedge clk)
   begin
      cycle_count <= cycle_count + 1;
      if (cycle_limit > 0 && cycle_count >= cycle_limit)
      begin
         $display("Timeout: the run did not finish within %0d cycles.", cycle_limit);
         $display("STATUS: FAIL");
         $finish;
      end
   end

   initial
   begin
      cmd_valid <= 1'b0;
      cmd_write <= 1'b0;
      cmd_addr <= '0;
      cmd_data <= '0;
      resp_ready <= 1'b0;
      exp_data <= '0;
      exp_nxm <= 1'b0;
      exp_prom <= 1'b0;
      report <= 1'b0;
      rand_word = $urandom(32'h7ef26ec8);
      n_entries = 0;
      build_table();
      cycle_limit = n_entries * (timeout_cycles + 10) + 50;
      @(posedge clk);
      while (reset)
         @(posedge clk);
      for (idx = 0; idx < n_entries; idx++)
      begin
         cmd_valid <= 1'b1;
         cmd_write <= tbl_write[idx];
         cmd_addr <= tbl_addr[idx];
         cmd_data <= tbl_data[idx];
         exp_data <= tbl_exp_data[idx];
         exp_nxm <= tbl_exp_nxm[idx];
         exp_prom <= tbl_exp_prom[idx];
         @(posedge clk);
         while (!cmd_ready)
            @(posedge clk);
         cmd_valid <= 1'b0;
         @(posedge clk);
         while (!resp_valid)
            @(posedge clk);
         rand_word = $urandom;
         stall = int'(rand_word[1:0]);     // Random back-pressure.
         repeat (stall) @(posedge clk);
         resp_ready <= 1'b1;
         @(posedge clk);
         resp_ready <= 1'b0;
      end
      report <= 1'b1;
      repeat (2) @(posedge clk);
      if (error_count == 0 && response_count == n_entries)
         $display("STATUS: PASS");
      else
      begin
         if (response_count != n_entries)
            $display("Only %0d of %0d commands got a response.", response_count, n_entries);
         $display("STATUS: FAIL");
      end
      $finish;
   end

endmodule

//--- xbus.f
common/xbus_pkg.sv
logic/xbus_ctl.sv
unibus/xbus_unibus.sv
logic/xbus_ram.sv
logic/xbus_top.sv
test/xbus_clk_gen.sv
test/xbus_checker.sv
test/xbus_tb.sv

//--- run_sim.sh
#!/bin/sh
rm -f sim.log
verilator --binary --timing -f xbus.f --top-module xbus_tb --Mdir obj_dir -o xbus_sim &&
   ./obj_dir/xbus_sim > sim.log 2>&1 ||
   echo "Build or simulation stopped with an error."
cat sim.log 2>/dev/null
grep -q "^STATUS: PASS$" sim.log && exit 0 || exit 1
